//--- src/snoop_pkg.sv
package snoop_pkg;

  // axi read data width, also the stream tdata width
  localparam int data_width = 64;
  // axi address width
  localparam int addr_width = 32;
  // axi id width
  localparam int id_width = 4;
  // burst length field, beats minus one
  localparam int len_width = 8;
  // one strobe bit per data byte
  localparam int strb_width = data_width / 8;

  // record tag sits in the top byte of a header beat
  localparam int tag_width = 8;
  // tag for a read address record
  localparam logic [tag_width-1:0] tag_ar = 8'h01;

  // read address channel payload
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [addr_width-1:0] addr;
    logic [len_width-1:0]  len;
  } ar_chan_t;

  // read data channel payload
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } r_chan_t;

  // one beat on the stream side, tkeep is implied all ones
  typedef struct packed {
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
    logic                  last;
  } stream_beat_t;

  // which record the builder is asked to produce
  typedef enum logic {
    rec_header,
    rec_data
  } rec_kind_t;

endpackage

//--- src/snoop_ctrl.sv
`timescale 1ns/1ps

module snoop_ctrl (
  input  logic                 clk,
  input  logic                 resetn,
  // ar handshake halves, seen before gating
  input  logic                 snoop_arvalid,
  input  logic                 forward_arready,
  // r handshake halves, seen before gating
  input  logic                 snoop_rready,
  input  logic                 forward_rvalid,
  input  logic                 r_last,
  // output register has room for a beat this cycle
  input  logic                 can_push,
  output logic                 ar_open,
  output logic                 r_open,
  output logic                 ar_capture,
  output logic                 push,
  output snoop_pkg::rec_kind_t kind
);

  import snoop_pkg::*;

  // idle waits for an ar
  // header emits the address record
  // data follows r beats up to rlast
  typedef enum logic [1:0] {
    st_idle,
    st_header,
    st_data
  } state_t;

  state_t state;
  state_t state_next;

  // completed handshakes on the gated pairs
  logic ar_hs;
  logic r_hs;

  // ar only passes when no packet is in flight
  // and the output register can take the header soon after
  assign ar_open = (state == st_idle) && can_push;

  // r beats only pass while we can copy them out in the same cycle
  assign r_open = (state == st_data) && can_push;

  assign ar_hs = ar_open && snoop_arvalid && forward_arready;
  assign r_hs  = r_open && forward_rvalid && snoop_rready;

  // builder latches address and length on this pulse
  assign ar_capture = ar_hs;

  // header push waits for room, data push rides on the r handshake
  always_comb begin
    push = 1'b0;
    kind = rec_data;
    case (state)
      st_header: begin
        kind = rec_header;
        push = can_push;
      end
      st_data: begin
        kind = rec_data;
        push = r_hs;
      end
      default: begin
        kind = rec_data;
        push = 1'b0;
      end
    endcase
  end

  // next state
  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (ar_hs) begin
          state_next = st_header;
        end
      end
      st_header: begin
        // header goes out once the register has room
        if (can_push) begin
          state_next = st_data;
        end
      end
      st_data: begin
        // packet ends with the beat carrying rlast
        if (r_hs && r_last) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- src/stream_record_builder.sv
`timescale 1ns/1ps

module stream_record_builder (
  input  logic                    clk,
  input  logic                    resetn,
  // latch the ar fields for the header one cycle later
  input  logic                    ar_capture,
  input  snoop_pkg::ar_chan_t     ar_in,
  // current r beat, already gated by the controller
  input  snoop_pkg::r_chan_t      r_in,
  input  snoop_pkg::rec_kind_t    kind,
  output snoop_pkg::stream_beat_t beat
);

  import snoop_pkg::*;

  // captured burst address and length
  logic [addr_width-1:0] cap_addr;
  logic [len_width-1:0]  cap_len;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cap_addr <= '0;
      cap_len  <= '0;
    end else if (ar_capture) begin
      cap_addr <= ar_in.addr;
      cap_len  <= ar_in.len;
    end
  end

  always_comb begin
    beat = '0;
    case (kind)
      rec_header: begin
        // tag on top, length below it, address in the low bytes
        // bytes between length and address stay zero
        beat.data = {tag_ar, cap_len,
                     {(data_width - tag_width - len_width - addr_width){1'b0}},
                     cap_addr};
        // strobe marks only the meaningful header bytes
        beat.strb = {{(tag_width / 8){1'b1}},
                     {(len_width / 8){1'b1}},
                     {((data_width - tag_width - len_width - addr_width) / 8){1'b0}},
                     {(addr_width / 8){1'b1}}};
        // a header never closes a packet
        beat.last = 1'b0;
      end
      default: begin
        // read data passes untouched
        beat.data = r_in.data;
        beat.strb = '1;
        // rlast ends the stream packet too
        beat.last = r_in.last;
      end
    endcase
  end

endmodule

//--- src/stream_out_reg.sv
`timescale 1ns/1ps

module stream_out_reg (
  input  logic                    clk,
  input  logic                    resetn,
  // load strobe from the controller
  input  logic                    push,
  input  snoop_pkg::stream_beat_t beat_in,
  input  logic                    stream_tready,
  // room for a new beat this cycle
  output logic                    can_push,
  output logic                    stream_tvalid,
  output snoop_pkg::stream_beat_t beat_out
);

  import snoop_pkg::*;

  // single entry, flag plus payload
  logic         full;
  stream_beat_t beat_q;

  // empty, or the held beat leaves this cycle
  assign can_push = !full || stream_tready;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      full <= 1'b0;
    end else if (push) begin
      // new beat replaces one being drained
      full <= 1'b1;
    end else if (stream_tready) begin
      full <= 1'b0;
    end
  end

  // payload only moves on a push
  // so the stream side holds still under back-pressure
  always_ff @(posedge clk) begin
    if (push) begin
      beat_q <= beat_in;
    end
  end

  assign stream_tvalid = full;
  assign beat_out      = beat_q;

endmodule

//--- src/axi_snoop_stream.sv
`timescale 1ns/1ps

module axi_snoop_stream (
  input  logic                    clk,
  input  logic                    resetn,
  // snooped master side
  input  snoop_pkg::ar_chan_t     snoop_ar,
  input  logic                    snoop_arvalid,
  output logic                    snoop_arready,
  output snoop_pkg::r_chan_t      snoop_r,
  output logic                    snoop_rvalid,
  input  logic                    snoop_rready,
  // forward slave side
  output snoop_pkg::ar_chan_t     forward_ar,
  output logic                    forward_arvalid,
  input  logic                    forward_arready,
  input  snoop_pkg::r_chan_t      forward_r,
  input  logic                    forward_rvalid,
  output logic                    forward_rready,
  // stream copy of each read
  output snoop_pkg::stream_beat_t stream_beat,
  output logic                    stream_tvalid,
  input  logic                    stream_tready
);

  import snoop_pkg::*;

  // gates from the controller
  logic ar_open;
  logic r_open;

  // controller to builder and output register
  logic         ar_capture;
  logic         push;
  rec_kind_t    kind;
  logic         can_push;
  stream_beat_t built_beat;

  // payloads go straight through
  assign forward_ar = snoop_ar;
  assign snoop_r    = forward_r;

  // ar handshake only while idle with room downstream
  assign forward_arvalid = snoop_arvalid && ar_open;
  assign snoop_arready   = forward_arready && ar_open;

  // r handshake only inside a packet with room downstream
  assign snoop_rvalid   = forward_rvalid && r_open;
  assign forward_rready = snoop_rready && r_open;

  snoop_ctrl i_snoop_ctrl (
    .clk             (clk),
    .resetn          (resetn),
    .snoop_arvalid   (snoop_arvalid),
    .forward_arready (forward_arready),
    .snoop_rready    (snoop_rready),
    .forward_rvalid  (forward_rvalid),
    .r_last          (forward_r.last),
    .can_push        (can_push),
    .ar_open         (ar_open),
    .r_open          (r_open),
    .ar_capture      (ar_capture),
    .push            (push),
    .kind            (kind)
  );

  // header from the captured ar, data from the live r beat
  stream_record_builder i_stream_record_builder (
    .clk        (clk),
    .resetn     (resetn),
    .ar_capture (ar_capture),
    .ar_in      (snoop_ar),
    .r_in       (forward_r),
    .kind       (kind),
    .beat       (built_beat)
  );

  // one beat of buffering toward the stream sink
  stream_out_reg i_stream_out_reg (
    .clk           (clk),
    .resetn        (resetn),
    .push          (push),
    .beat_in       (built_beat),
    .stream_tready (stream_tready),
    .can_push      (can_push),
    .stream_tvalid (stream_tvalid),
    .beat_out      (stream_beat)
  );

endmodule

//--- tests/tb_axi_snoop_stream.sv
`timescale 1ns/1ps

module tb_axi_snoop_stream;

  import snoop_pkg::*;

  localparam int num_reads  = 12;
  localparam int exp_depth  = 256;
  localparam int wait_limit = 1000;

  logic         clk;
  logic         resetn;
  ar_chan_t     snoop_ar;
  logic         snoop_arvalid;
  logic         snoop_arready;
  r_chan_t      snoop_r;
  logic         snoop_rvalid;
  logic         snoop_rready;
  ar_chan_t     forward_ar;
  logic         forward_arvalid;
  logic         forward_arready;
  r_chan_t      forward_r;
  logic         forward_rvalid;
  logic         forward_rready;
  stream_beat_t stream_beat;
  logic         stream_tvalid;
  logic         stream_tready;

  int seed     = 32'h95a3_7466;
  int errors   = 0;
  int timeouts = 0;

  // expected stream beats in arrival order
  stream_beat_t exp_mem [exp_depth];
  int           exp_count = 0;

  // scoreboard state is updated on the falling edge
  int           rx_idx        = 0;
  stream_beat_t exp_front     = '0;
  logic         exp_avail     = 1'b0;
  logic         stream_fire_q = 1'b0;
  logic         ar_fire_q     = 1'b0;
  logic         rlast_fire_q  = 1'b0;
  logic         packet_open   = 1'b0;
  logic         stall_now     = 1'b0;
  logic         stall_prev    = 1'b0;
  stream_beat_t cur_beat      = '0;
  stream_beat_t prev_beat     = '0;
  // set once the master first raises arvalid
  logic         ar_offered    = 1'b0;

  always #5 clk = ~clk;

  axi_snoop_stream i_axi_snoop_stream (
    .clk             (clk),
    .resetn          (resetn),
    .snoop_ar        (snoop_ar),
    .snoop_arvalid   (snoop_arvalid),
    .snoop_arready   (snoop_arready),
    .snoop_r         (snoop_r),
    .snoop_rvalid    (snoop_rvalid),
    .snoop_rready    (snoop_rready),
    .forward_ar      (forward_ar),
    .forward_arvalid (forward_arvalid),
    .forward_arready (forward_arready),
    .forward_r       (forward_r),
    .forward_rvalid  (forward_rvalid),
    .forward_rready  (forward_rready),
    .stream_beat     (stream_beat),
    .stream_tvalid   (stream_tvalid),
    .stream_tready   (stream_tready)
  );

  // header has the tag in byte 7 and the length in byte 6
  // bytes 5 and 4 stay zero and the address fills bytes 3 to 0
  function automatic stream_beat_t header_beat(input logic [31:0] addr,
                                               input logic [7:0] len);
    stream_beat_t b;
    b              = '0;
    b.data[63:56]  = tag_ar;
    b.data[55:48]  = len;
    b.data[31:0]   = addr;
    b.strb         = 8'b1100_1111;
    b.last         = 1'b0;
    return b;
  endfunction

  function automatic stream_beat_t data_beat(input logic [63:0] data, input logic last);
    stream_beat_t b;
    b.data = data;
    b.strb = '1;
    b.last = last;
    return b;
  endfunction

  task automatic push_expected(input stream_beat_t b);
    if (exp_count < exp_depth) begin
      exp_mem[exp_count] = b;
      exp_count          = exp_count + 1;
    end
  endtask

  // offer one AR on the snoop port and hold it until accepted
  task automatic issue_read(input logic [31:0] addr, input logic [7:0] len,
                            input logic [3:0] id, output bit ok);
    int waited;
    ok            = 1'b0;
    waited        = 0;
    snoop_ar.id   = id;
    snoop_ar.addr = addr;
    snoop_ar.len  = len;
    snoop_arvalid = 1'b1;
    ar_offered    = 1'b1;
    while (!ok && waited < wait_limit) begin
      @(negedge clk);
      if (snoop_arready) begin
        ok = 1'b1;
        push_expected(header_beat(addr, len));
      end else begin
        waited++;
      end
    end
    @(posedge clk);
    #1;
    snoop_arvalid = 1'b0;
    if (!ok) begin
      $display("timeout: AR with address %h was never accepted", addr);
      timeouts++;
    end
  endtask

  task automatic run_master();
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [7:0]  len;
    bit          ok;
    int          i;
    // bus stays quiet for a few cycles after reset
    repeat (4) begin
      @(posedge clk);
      #1;
    end
    for (i = 0; i < num_reads; i++) begin
      rnd  = $random(seed);
      addr = {rnd[31:3], 3'b000};
      rnd  = $random(seed);
      // first read is a single beat and later ones take up to eight
      len  = (i == 0) ? 8'd0 : {5'd0, rnd[2:0]};
      issue_read(addr, len, 4'(i), ok);
      if (!ok) begin
        return;
      end
      // short idle gap between reads
      repeat (rnd[5:4]) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  // forward slave model where ready follows valid and each AR gets len+1 beats
  task automatic serve_read(output bit ok);
    int          waited;
    int          beats;
    int          b;
    bit          got;
    logic [3:0]  id;
    logic [31:0] rnd_hi;
    logic [31:0] rnd_lo;
    ok     = 1'b0;
    got    = 1'b0;
    waited = 0;
    beats  = 0;
    id     = '0;
    while (!got && waited < wait_limit) begin
      @(negedge clk);
      if (forward_arvalid && forward_arready) begin
        got   = 1'b1;
        beats = int'(forward_ar.len) + 1;
        id    = forward_ar.id;
      end else begin
        waited++;
        if (forward_arvalid) begin
          @(posedge clk);
          #1;
          forward_arready = 1'b1;
        end
      end
    end
    @(posedge clk);
    #1;
    forward_arready = 1'b0;
    if (!got) begin
      $display("timeout: no AR reached the forward port");
      timeouts++;
    end else begin
      b  = 0;
      ok = 1'b1;
      while (ok && b < beats) begin
        rnd_hi         = $random(seed);
        rnd_lo         = $random(seed);
        forward_r.id   = id;
        forward_r.data = {rnd_hi, rnd_lo};
        forward_r.resp = 2'b00;
        forward_r.last = (b == beats - 1);
        forward_rvalid = 1'b1;
        push_expected(data_beat({rnd_hi, rnd_lo}, b == beats - 1));
        got    = 1'b0;
        waited = 0;
        while (!got && waited < wait_limit) begin
          @(negedge clk);
          if (forward_rready) begin
            got = 1'b1;
          end else begin
            waited++;
          end
        end
        if (!got) begin
          $display("timeout: R beat %0d was never taken by the snoop port", b);
          timeouts++;
          ok = 1'b0;
        end
        @(posedge clk);
        #1;
        b++;
      end
      forward_rvalid = 1'b0;
      forward_r.last = 1'b0;
    end
  endtask

  task automatic run_slave();
    int n;
    bit ok;
    n  = 0;
    ok = 1'b1;
    while (ok && n < num_reads) begin
      serve_read(ok);
      n++;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((rx_idx < exp_count || stream_tvalid) && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    if (rx_idx < exp_count || stream_tvalid) begin
      $display("timeout: only %0d of %0d stream beats arrived", rx_idx, exp_count);
      timeouts++;
    end
  endtask

  // random sink back-pressure and master rready
  initial begin
    logic [31:0] rnd;
    stream_tready = 1'b0;
    snoop_rready  = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      rnd           = $random(seed);
      stream_tready = resetn && (rnd[1:0] != 2'd0);
      snoop_rready  = resetn && (rnd[3:2] != 2'd0);
    end
  end

  // falling edge view of the buses
  // fired handshakes are counted one cycle later
  always @(negedge clk) begin
    if (!resetn) begin
      rx_idx        = 0;
      stream_fire_q = 1'b0;
      ar_fire_q     = 1'b0;
      rlast_fire_q  = 1'b0;
      packet_open   = 1'b0;
      stall_now     = 1'b0;
      stall_prev    = 1'b0;
    end else begin
      if (stream_fire_q) begin
        rx_idx = rx_idx + 1;
      end
      if (ar_fire_q) begin
        packet_open = 1'b1;
      end
      if (rlast_fire_q) begin
        packet_open = 1'b0;
      end
      stream_fire_q = stream_tvalid && stream_tready;
      ar_fire_q     = snoop_arvalid && snoop_arready;
      rlast_fire_q  = forward_rvalid && forward_rready && forward_r.last;
      stall_prev    = stall_now;
      stall_now     = stream_tvalid && !stream_tready;
    end
    prev_beat = cur_beat;
    cur_beat  = stream_beat;
    exp_avail = (rx_idx < exp_count) && (rx_idx < exp_depth);
    exp_front = exp_avail ? exp_mem[rx_idx] : '0;
  end

  // nothing moves before the first AR
  reset_state_chk: assert property (@(posedge clk) disable iff (!resetn)
    !ar_offered |-> (!stream_tvalid && !snoop_arready && !forward_arvalid))
    else begin
      errors++;
      $display("** Error %0t: stream_tvalid=%b snoop_arready=%b forward_arvalid=%b, expected 0",
               $time, stream_tvalid, snoop_arready, forward_arvalid);
    end

  beat_pending_chk: assert property (@(posedge clk) disable iff (!resetn)
    (stream_tvalid && stream_tready) |-> exp_avail)
    else begin
      errors++;
      $display("stream beat delivered at %0t with no beat expected", $time);
    end

  // header and data records in order with strobe and last
  beat_value_chk: assert property (@(posedge clk) disable iff (!resetn)
    (stream_tvalid && stream_tready && exp_avail) |-> (stream_beat == exp_front))
    else begin
      errors++;
      $display("** Error %0t: stream_beat got %h expected %h", $time, cur_beat, exp_front);
    end

  hold_chk: assert property (@(posedge clk) disable iff (!resetn)
    stall_prev |-> (stream_tvalid && stream_beat == prev_beat))
    else begin
      errors++;
      $display("** Error %0t: stream_beat got %h expected %h (held), tvalid %b",
               $time, cur_beat, prev_beat, stream_tvalid);
    end

  // a stalled stream closes both AXI gates
  stall_gate_chk: assert property (@(posedge clk) disable iff (!resetn)
    (stream_tvalid && !stream_tready) |-> (!forward_rready && !snoop_arready))
    else begin
      errors++;
      $display("** Error %0t: forward_rready=%b snoop_arready=%b, expected 0 under stall",
               $time, forward_rready, snoop_arready);
    end

  r_pass_chk: assert property (@(posedge clk) disable iff (!resetn)
    (forward_rvalid && forward_rready) |-> (snoop_rvalid && snoop_r == forward_r))
    else begin
      errors++;
      $display("** Error %0t: snoop_r got %h expected %h, snoop_rvalid %b",
               $time, snoop_r, forward_r, snoop_rvalid);
    end

  ar_pass_chk: assert property (@(posedge clk) disable iff (!resetn)
    forward_arvalid |-> (snoop_arvalid && forward_ar == snoop_ar))
    else begin
      errors++;
      $display("** Error %0t: forward_ar got %h expected %h", $time, forward_ar, snoop_ar);
    end

  one_packet_chk: assert property (@(posedge clk) disable iff (!resetn)
    (snoop_arvalid && snoop_arready) |-> !packet_open)
    else begin
      errors++;
      $display("new AR accepted at %0t while the previous packet was still open", $time);
    end

  initial begin
    clk             = 1'b0;
    resetn          = 1'b0;
    snoop_ar        = '0;
    snoop_arvalid   = 1'b0;
    forward_arready = 1'b0;
    forward_r       = '0;
    forward_rvalid  = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    resetn = 1'b1;
    fork
      run_master();
      run_slave();
    join
    wait_drain();
    $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- flist.f
src/snoop_pkg.sv
src/snoop_ctrl.sv
src/stream_record_builder.sv
src/stream_out_reg.sv
src/axi_snoop_stream.sv
tests/tb_axi_snoop_stream.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the snoop testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

log_file="sim.log"
top="tb_axi_snoop_stream"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module "$top" -Mdir obj_dir -o sim_tb -f flist.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints its pass line only when every check held
if grep -qx "Finished with no errors" "$log_file"; then
  echo "run passed"
  exit 0
fi

echo "run failed, see $log_file"
exit 1
